/* filelist.f */
+incdir+src
src/rv_core_pkg.sv
src/rv_decoder.sv
src/rv_execute.sv
src/rv_regfile.sv
src/rv_csr_file.sv
src/rv_lsu.sv
src/rv_core.sv
sim/rv_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run with Verilator, then look for the pass line in the log
verilator --binary --timing -Wno-fatal --top-module rv_core_tb -f filelist.f \
	-o rv_core_sim \
	&& ./obj_dir/rv_core_sim > sim.log 2>&1 \
	|| { echo "build or run failed"; exit 1; }
cat sim.log
grep -q "SIMULATION PASSED" sim.log \
	&& echo "run_sim: pass" \
	|| { echo "run_sim: fail"; exit 1; }

/* sim/rv_core_stimulus.txt */
# Columns: I addr word / D addr word / R pc rd value wen / S addr data strobe
# All values in hex, rd and value are only compared when wen is 1
I 30000000 000010b7
I 30000004 00000117
I 30000008 12300193
I 3000000c 00318233
I 30000010 00500013
I 30000014 004002b3
I 30000018 0040a423
I 3000001c 0080a303
I 30000020 0000a383
I 30000024 00418463
I 30000028 00430463
I 3000002c 00100413
I 30000030 0080046f
I 30000034 00200413
I 30000038 04010493
I 3000003c 00048567
I 30000040 00700513
I 30000044 0fc10593
I 30000048 30559073
I 3000004c 00000073
I 30000050 00d0a223
I 30000054 ffffffff
I 30000058 00d0a023
I 3000005c 0000006f
# Trap handler steps mepc past the trapping word
I 30000100 34102673
I 30000104 342026f3
I 30000108 00460613
I 3000010c 34161073
I 30000110 30200073
D 00001000 cafef00d
D 00001004 13579bdf
R 30000000 1 00001000 1
R 30000004 2 30000004 1
R 30000008 3 00000123 1
R 3000000c 4 00000246 1
R 30000010 0 00000000 0
R 30000014 5 00000246 1
R 30000018 0 00000000 0
R 3000001c 6 00000246 1
R 30000020 7 cafef00d 1
R 30000024 0 00000000 0
R 30000028 0 00000000 0
R 30000030 8 30000034 1
R 30000038 9 30000044 1
R 3000003c a 30000040 1
R 30000044 b 30000100 1
R 30000048 0 00000000 0
R 3000004c 0 00000000 0
R 30000100 c 3000004c 1
R 30000104 d 0000000b 1
R 30000108 c 30000050 1
R 3000010c 0 00000000 0
R 30000110 0 00000000 0
R 30000050 0 00000000 0
R 30000054 0 00000000 0
R 30000100 c 30000054 1
R 30000104 d 00000002 1
R 30000108 c 30000058 1
R 3000010c 0 00000000 0
R 30000110 0 00000000 0
R 30000058 0 00000000 0
R 3000005c 0 00000000 0
S 00001008 00000246 f
S 00001004 0000000b f
S 00001000 00000002 f

/* sim/rv_core_tb.sv */
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module rv_core_tb;
	import rv_core_pkg::*;

	logic     clock;
	logic     rst_n;
	mem_req_t imem_req;
	logic     imem_req_valid;
	mem_rsp_t imem_rsp = '0;
	logic     imem_rsp_valid = 1'b0;
	mem_req_t dmem_req;
	logic     dmem_req_valid;
	mem_rsp_t dmem_rsp = '0;
	logic     dmem_rsp_valid = 1'b0;
	retire_t  retire;
	logic     retire_valid;

	integer seed = 32'h39e3_042e;
	int     errors = 0;
	int     cycles = 0;
	int     limit = 0;
	int     ridx = 0;
	int     sidx = 0;
	int     imem_wait = 0;
	int     dmem_wait = 0;
	int     load_tag = 0;
	int     load_seen = 0;
	logic   fetch_seen = 1'b0;
	logic   got_irsp = 1'b0;

	logic [31:0] imem_data;
	logic [31:0] dmem_data;
	logic [31:0] last_load;

	// Program and data images keyed by byte address
	logic [31:0] imem_words [logic [31:0]];
	logic [31:0] dmem_words [logic [31:0]];

	logic [31:0] exp_pc [$];
	logic [31:0] exp_rd [$];
	logic [31:0] exp_val [$];
	logic [31:0] exp_wen [$];
	logic [31:0] exp_saddr [$];
	logic [31:0] exp_sdata [$];
	logic [31:0] exp_sstrb [$];

	rv_core uut (
		.clock          (clock),
		.rst_n          (rst_n),
		.imem_req       (imem_req),
		.imem_req_valid (imem_req_valid),
		.imem_rsp       (imem_rsp),
		.imem_rsp_valid (imem_rsp_valid),
		.dmem_req       (dmem_req),
		.dmem_req_valid (dmem_req_valid),
		.dmem_rsp       (dmem_rsp),
		.dmem_rsp_valid (dmem_rsp_valid),
		.retire         (retire),
		.retire_valid   (retire_valid)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	// Words never loaded still differ from address to address
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return {addr[15:0], addr[31:16]} ^ 32'h6b3d_90c7;
	endfunction

	task automatic load_stimulus();
		int               fd;
		int               code;
		logic [63:0]      tag;
		logic [31:0]      a;
		logic [31:0]      b;
		logic [31:0]      c;
		logic [31:0]      d;
		logic [8*160-1:0] rest;
		fd = $fopen("sim/rv_core_stimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file sim/rv_core_stimulus.txt");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", tag);
			if (code != 1)
				break;
			if (tag == "#") begin
				code = $fgets(rest, fd);
			end else if (tag == "I") begin
				code = $fscanf(fd, "%h %h", a, b);
				imem_words[a] = b;
			end else if (tag == "D") begin
				code = $fscanf(fd, "%h %h", a, b);
				dmem_words[a] = b;
			end else if (tag == "R") begin
				code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
				exp_pc.push_back(a);
				exp_rd.push_back(b);
				exp_val.push_back(c);
				exp_wen.push_back(d);
			end else if (tag == "S") begin
				code = $fscanf(fd, "%h %h %h", a, b, c);
				exp_saddr.push_back(a);
				exp_sdata.push_back(b);
				exp_sstrb.push_back(c);
			end else begin
				$display("unknown line tag in the stimulus file");
				errors++;
			end
		end
		$fclose(fd);
	endtask

	// Instruction memory answering after 1 to 4 cycles
	always @(posedge clock) begin
		imem_rsp_valid <= 1'b0;
		if (imem_req_valid) begin
			if (!fetch_seen) begin
				check_value("imem_req.addr", imem_req.addr, `RV_RESET_PC);
				fetch_seen = 1'b1;
			end
			check_value("imem_req.write", {31'h0, imem_req.write}, 32'h0);
			imem_data = imem_words.exists(imem_req.addr) ? imem_words[imem_req.addr]
				: fill_word(imem_req.addr);
			imem_wait = 1 + ($unsigned($random(seed)) % 4);
		end
		if (imem_wait > 0) begin
			imem_wait = imem_wait - 1;
			if (imem_wait == 0) begin
				imem_rsp_valid <= 1'b1;
				imem_rsp.rdata <= imem_data;
			end
		end
	end

	// Data memory that checks every store against the expected list
	always @(posedge clock) begin
		dmem_rsp_valid <= 1'b0;
		if (dmem_req_valid) begin
			if (dmem_req.write) begin
				if (sidx >= exp_saddr.size()) begin
					$display("unexpected store to address %h", dmem_req.addr);
					errors++;
				end else begin
					check_value("dmem_req.addr", dmem_req.addr, exp_saddr[sidx]);
					check_value("dmem_req.wdata", dmem_req.wdata, exp_sdata[sidx]);
					check_value("dmem_req.wstrb", {28'h0, dmem_req.wstrb}, exp_sstrb[sidx]);
					sidx++;
				end
				dmem_words[dmem_req.addr] = dmem_req.wdata;
				dmem_data = '0;
			end else begin
				dmem_data = dmem_words.exists(dmem_req.addr) ? dmem_words[dmem_req.addr]
					: fill_word(dmem_req.addr);
				last_load = dmem_data;
				load_tag++;
			end
			dmem_wait = 1 + ($unsigned($random(seed)) % 4);
		end
		if (dmem_wait > 0) begin
			dmem_wait = dmem_wait - 1;
			if (dmem_wait == 0) begin
				dmem_rsp_valid <= 1'b1;
				dmem_rsp.rdata <= dmem_data;
			end
		end
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (rst_n && !got_irsp && (retire_valid || dmem_req_valid)) begin
			$display("retire or data request seen before the first instruction response");
			errors++;
		end
		if (imem_rsp_valid)
			got_irsp = 1'b1;
		if (rst_n && retire_valid) begin
			if (ridx >= exp_pc.size()) begin
				$display("retire at pc %h beyond the expected records", retire.pc);
				errors++;
			end else begin
				check_value("retire.pc", retire.pc, exp_pc[ridx]);
				check_value("retire.wen", {31'h0, retire.wen}, exp_wen[ridx]);
				if (exp_wen[ridx] != 0) begin
					check_value("retire.rd", {28'h0, retire.rd}, exp_rd[ridx]);
					check_value("retire.wdata", retire.wdata, exp_val[ridx]);
				end
				// A load since the last retire must return the model word
				if (load_seen != load_tag) begin
					if (exp_wen[ridx] != 0)
						check_value("lw retire.wdata", retire.wdata, last_load);
					load_seen = load_tag;
				end
				ridx <= ridx + 1;
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		load_stimulus();
		limit = exp_pc.size() * 12 + 50;
		if (exp_pc.size() == 0) begin
			$display("no retire records found in the stimulus file");
			errors++;
		end
		repeat (2) @(posedge clock);
		rst_n <= 1'b1;
		while (ridx < exp_pc.size() && cycles < limit)
			@(posedge clock);
		if (ridx < exp_pc.size()) begin
			$display("timeout after %0d cycles, %0d of %0d retires seen",
				cycles, ridx, exp_pc.size());
			errors++;
		end
		if (sidx != exp_saddr.size()) begin
			$display("only %0d of %0d expected stores were seen", sidx, exp_saddr.size());
			errors++;
		end
		$display("checked %0d retires and %0d stores, %0d errors", ridx, sidx, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* src/rv_core.sv */
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module rv_core (
	input  logic                  clock,
	input  logic                  rst_n,
	output rv_core_pkg::mem_req_t imem_req,
	output logic                  imem_req_valid,
	input  rv_core_pkg::mem_rsp_t imem_rsp,
	input  logic                  imem_rsp_valid,
	output rv_core_pkg::mem_req_t dmem_req,
	output logic                  dmem_req_valid,
	input  rv_core_pkg::mem_rsp_t dmem_rsp,
	input  logic                  dmem_rsp_valid,
	output rv_core_pkg::retire_t  retire,
	output logic                  retire_valid
);
	import rv_core_pkg::*;

	localparam logic [1:0] st_fetch = 2'd0;
	localparam logic [1:0] st_wait  = 2'd1;
	localparam logic [1:0] st_exec  = 2'd2;

	logic [1:0]  state;
	logic [31:0] pc;
	logic [31:0] snpc;
	logic [31:0] dnpc;
	inst_word_u  inst;
	dec_t        dec;
	logic        exec_first;
	logic        mem_ready;
	logic        is_mem;
	logic [31:0] src1;
	logic [31:0] src2;
	logic [31:0] alu_val;
	logic [31:0] redirect_pc;
	logic        take_redirect;
	logic [31:0] csr_rdata;
	logic [31:0] trap_pc;
	logic        trap_taken;
	logic [31:0] load_val;
	logic        lsu_done;
	logic [31:0] wb_val;

	assign snpc = pc + 32'd4;
	assign dnpc = trap_taken ? trap_pc : take_redirect ? redirect_pc : snpc;

	assign imem_req = '{addr: pc, wdata: '0, wstrb: 4'h0, write: 1'b0};

	assign is_mem = dec.kind == op_lw || dec.kind == op_sw;
	// Memory ops retire the cycle after the data response
	assign retire_valid = state == st_exec && (is_mem ? mem_ready : exec_first);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state          <= st_fetch;
			pc             <= `RV_RESET_PC;
			imem_req_valid <= 1'b0;
			exec_first     <= 1'b0;
			mem_ready      <= 1'b0;
		end else begin
			imem_req_valid <= 1'b0;
			exec_first     <= 1'b0;
			mem_ready      <= lsu_done;
			case (state)
				st_fetch: begin
					imem_req_valid <= 1'b1;
					state          <= st_wait;
				end
				st_wait: begin
					if (imem_rsp_valid) begin
						exec_first <= 1'b1;
						state      <= st_exec;
					end
				end
				st_exec: begin
					// Next fetch is strobed straight from the retire edge
					if (retire_valid) begin
						pc             <= dnpc;
						imem_req_valid <= 1'b1;
						state          <= st_wait;
					end
				end
				default: state <= st_fetch;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == st_wait && imem_rsp_valid)
			inst <= imem_rsp.rdata;
	end

	always_comb begin
		case (dec.kind)
			op_lw:              wb_val = load_val;
			op_jal, op_jalr:    wb_val = snpc;
			op_csrrw, op_csrrs: wb_val = csr_rdata;
			default:            wb_val = alu_val;
		endcase
	end

	assign retire = '{pc: pc, rd: dec.rd, wdata: wb_val, wen: dec.reg_wen};

	rv_decoder u_decoder (
		.inst (inst),
		.dec  (dec)
	);

	rv_execute u_execute (
		.dec           (dec),
		.pc            (pc),
		.src1          (src1),
		.src2          (src2),
		.alu_val       (alu_val),
		.redirect_pc   (redirect_pc),
		.take_redirect (take_redirect)
	);

	rv_regfile u_regfile (
		.clock  (clock),
		.rst_n  (rst_n),
		.raddr1 (dec.rs1),
		.raddr2 (dec.rs2),
		.rdata1 (src1),
		.rdata2 (src2),
		.we     (retire_valid && dec.reg_wen),
		.waddr  (dec.rd),
		.wdata  (wb_val)
	);

	rv_csr_file u_csr_file (
		.clock      (clock),
		.rst_n      (rst_n),
		.dec        (dec),
		.src1       (src1),
		.pc         (pc),
		.commit     (retire_valid),
		.csr_rdata  (csr_rdata),
		.trap_taken (trap_taken),
		.trap_pc    (trap_pc)
	);

	rv_lsu u_lsu (
		.clock          (clock),
		.rst_n          (rst_n),
		.start          (exec_first),
		.dec            (dec),
		.addr           (alu_val),
		.store_data     (src2),
		.dmem_req       (dmem_req),
		.dmem_req_valid (dmem_req_valid),
		.dmem_rsp       (dmem_rsp),
		.dmem_rsp_valid (dmem_rsp_valid),
		.load_val       (load_val),
		.done           (lsu_done)
	);

endmodule

/* src/rv_core_consts.svh */
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

`define RV_RESET_PC 32'h3000_0000
`define RV_REG_COUNT 16

// Machine CSR numbers
`define RV_CSR_MSTATUS 12'h300
`define RV_CSR_MTVEC 12'h305
`define RV_CSR_MEPC 12'h341
`define RV_CSR_MCAUSE 12'h342

`endif

/* src/rv_core_pkg.sv */
package rv_core_pkg;

	// One instruction word read through the four base formats
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r_fmt;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i_fmt;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s_fmt;
		struct packed {
			logic [19:0] imm;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u_fmt;
	} inst_word_u;

	typedef enum logic [3:0] {
		op_lui, op_auipc, op_jal, op_jalr, op_beq, op_lw, op_sw,
		op_addi, op_add, op_csrrw, op_csrrs, op_ecall, op_mret, op_illegal
	} op_kind_e;

	typedef struct packed {
		op_kind_e    kind;
		logic [3:0]  rd;
		logic [3:0]  rs1;
		logic [3:0]  rs2;
		logic [31:0] imm;
		logic [11:0] csr_addr;
		logic        reg_wen;
	} dec_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        write;
	} mem_req_t;

	typedef struct packed {
		logic [31:0] rdata;
	} mem_rsp_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [3:0]  rd;
		logic [31:0] wdata;
		logic        wen;
	} retire_t;

endpackage

/* src/rv_csr_file.sv */
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module rv_csr_file (
	input  logic              clock,
	input  logic              rst_n,
	input  rv_core_pkg::dec_t dec,
	input  logic [31:0]       src1,
	input  logic [31:0]       pc,
	input  logic              commit,
	output logic [31:0]       csr_rdata,
	output logic              trap_taken,
	output logic [31:0]       trap_pc
);
	import rv_core_pkg::*;

	logic [31:0] mstatus;
	logic [31:0] mtvec;
	logic [31:0] mepc;
	logic [31:0] mcause;
	logic [31:0] csr_wdata;
	logic        csr_we;
	logic        trap_enter;

	always_comb begin
		case (dec.csr_addr)
			`RV_CSR_MSTATUS: csr_rdata = mstatus;
			`RV_CSR_MTVEC:   csr_rdata = mtvec;
			`RV_CSR_MEPC:    csr_rdata = mepc;
			`RV_CSR_MCAUSE:  csr_rdata = mcause;
			default:         csr_rdata = '0;
		endcase
	end

	assign csr_we    = commit && (dec.kind == op_csrrw || dec.kind == op_csrrs);
	assign csr_wdata = (dec.kind == op_csrrw) ? src1 : (csr_rdata | src1);

	assign trap_enter = dec.kind == op_ecall || dec.kind == op_illegal;
	assign trap_taken = trap_enter || dec.kind == op_mret;
	// Direct mode only
	assign trap_pc    = (dec.kind == op_mret) ? mepc : {mtvec[31:2], 2'b00};

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			mstatus <= 32'h0000_1800;
			mtvec   <= '0;
			mepc    <= '0;
			mcause  <= '0;
		end else if (commit && trap_enter) begin
			mepc        <= pc;
			mcause      <= (dec.kind == op_ecall) ? 32'd11 : 32'd2;
			// MIE saved into MPIE
			mstatus[7]  <= mstatus[3];
			mstatus[3]  <= 1'b0;
		end else if (commit && dec.kind == op_mret) begin
			mstatus[3]  <= mstatus[7];
			mstatus[7]  <= 1'b1;
		end else if (csr_we) begin
			case (dec.csr_addr)
				`RV_CSR_MSTATUS: mstatus <= csr_wdata;
				`RV_CSR_MTVEC:   mtvec   <= csr_wdata;
				`RV_CSR_MEPC:    mepc    <= csr_wdata;
				`RV_CSR_MCAUSE:  mcause  <= csr_wdata;
				default:         mcause  <= mcause;
			endcase
		end
	end

endmodule

/* src/rv_decoder.sv */
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module rv_decoder (
	input  rv_core_pkg::inst_word_u inst,
	output rv_core_pkg::dec_t       dec
);
	import rv_core_pkg::*;

	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;
	logic        rd_ok;
	logic        rs1_ok;
	logic        rs2_ok;
	logic        csr_ok;
	op_kind_e    kind;

	assign opcode = inst.r_fmt.opcode;
	assign funct3 = inst.i_fmt.funct3;

	assign imm_i = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
	assign imm_s = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
	// B and J are the S and U layouts with scrambled bits
	assign imm_b = {{19{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi[6], inst.s_fmt.imm_lo[0],
		inst.s_fmt.imm_hi[5:0], inst.s_fmt.imm_lo[4:1], 1'b0};
	assign imm_u = {inst.u_fmt.imm, 12'h000};
	assign imm_j = {{11{inst.u_fmt.imm[19]}}, inst.u_fmt.imm[19], inst.u_fmt.imm[7:0],
		inst.u_fmt.imm[8], inst.u_fmt.imm[18:9], 1'b0};

	// Only x0 to x15 exist
	assign rd_ok  = inst.r_fmt.rd < `RV_REG_COUNT;
	assign rs1_ok = inst.r_fmt.rs1 < `RV_REG_COUNT;
	assign rs2_ok = inst.r_fmt.rs2 < `RV_REG_COUNT;
	assign csr_ok = inst.i_fmt.imm inside {`RV_CSR_MSTATUS, `RV_CSR_MTVEC,
		`RV_CSR_MEPC, `RV_CSR_MCAUSE};

	always_comb begin
		kind = op_illegal;
		case (opcode)
			7'b0110111: if (rd_ok) kind = op_lui;
			7'b0010111: if (rd_ok) kind = op_auipc;
			7'b1101111: if (rd_ok) kind = op_jal;
			7'b1100111: if (funct3 == 3'b000 && rd_ok && rs1_ok) kind = op_jalr;
			7'b1100011: if (funct3 == 3'b000 && rs1_ok && rs2_ok) kind = op_beq;
			7'b0000011: if (funct3 == 3'b010 && rd_ok && rs1_ok) kind = op_lw;
			7'b0100011: if (funct3 == 3'b010 && rs1_ok && rs2_ok) kind = op_sw;
			7'b0010011: if (funct3 == 3'b000 && rd_ok && rs1_ok) kind = op_addi;
			7'b0110011: begin
				if (funct3 == 3'b000 && inst.r_fmt.funct7 == 7'h00 && rd_ok && rs1_ok && rs2_ok)
					kind = op_add;
			end
			7'b1110011: begin
				if (funct3 == 3'b001 && rd_ok && rs1_ok && csr_ok)
					kind = op_csrrw;
				else if (funct3 == 3'b010 && rd_ok && rs1_ok && csr_ok)
					kind = op_csrrs;
				else if (inst == 32'h0000_0073)
					kind = op_ecall;
				else if (inst == 32'h3020_0073)
					kind = op_mret;
			end
			default: kind = op_illegal;
		endcase
	end

	always_comb begin
		dec.kind     = kind;
		dec.rd       = inst.r_fmt.rd[3:0];
		dec.rs1      = inst.r_fmt.rs1[3:0];
		dec.rs2      = inst.r_fmt.rs2[3:0];
		dec.csr_addr = inst.i_fmt.imm;
		case (kind)
			op_lui, op_auipc: dec.imm = imm_u;
			op_jal:           dec.imm = imm_j;
			op_beq:           dec.imm = imm_b;
			op_sw:            dec.imm = imm_s;
			default:          dec.imm = imm_i;
		endcase
		case (kind)
			op_lui, op_auipc, op_jal, op_jalr, op_lw, op_addi, op_add, op_csrrw, op_csrrs:
				dec.reg_wen = inst.r_fmt.rd != 5'd0;
			default:
				dec.reg_wen = 1'b0;
		endcase
	end

endmodule

/* src/rv_execute.sv */
`timescale 1ns/1ps

module rv_execute (
	input  rv_core_pkg::dec_t dec,
	input  logic [31:0]       pc,
	input  logic [31:0]       src1,
	input  logic [31:0]       src2,
	output logic [31:0]       alu_val,
	output logic [31:0]       redirect_pc,
	output logic              take_redirect
);
	import rv_core_pkg::*;

	logic        pc_based;
	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [31:0] sum;

	// One adder serves sums, addresses and jump targets
	assign pc_based = dec.kind inside {op_auipc, op_jal, op_beq};
	assign op_a     = pc_based ? pc : src1;
	assign op_b     = (dec.kind == op_add) ? src2 : dec.imm;
	assign sum      = op_a + op_b;

	assign alu_val = (dec.kind == op_lui) ? dec.imm : sum;

	// Bit 0 cleared for jalr and already zero for pc relative targets
	assign redirect_pc = {sum[31:1], 1'b0};

	always_comb begin
		case (dec.kind)
			op_jal, op_jalr: take_redirect = 1'b1;
			op_beq:          take_redirect = src1 == src2;
			default:         take_redirect = 1'b0;
		endcase
	end

endmodule

/* src/rv_lsu.sv */
`timescale 1ns/1ps

module rv_lsu (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  start,
	input  rv_core_pkg::dec_t     dec,
	input  logic [31:0]           addr,
	input  logic [31:0]           store_data,
	output rv_core_pkg::mem_req_t dmem_req,
	output logic                  dmem_req_valid,
	input  rv_core_pkg::mem_rsp_t dmem_rsp,
	input  logic                  dmem_rsp_valid,
	output logic [31:0]           load_val,
	output logic                  done
);
	import rv_core_pkg::*;

	logic busy;
	logic is_load;
	logic is_store;

	assign is_load  = dec.kind == op_lw;
	assign is_store = dec.kind == op_sw;

	// Word accesses only so the low address bits are dropped
	assign dmem_req_valid = start && (is_load || is_store) && !busy;
	assign dmem_req.addr  = {addr[31:2], 2'b00};
	assign dmem_req.wdata = store_data;
	assign dmem_req.wstrb = is_store ? 4'hf : 4'h0;
	assign dmem_req.write = is_store;

	assign done = busy && dmem_rsp_valid;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			busy <= 1'b0;
		else if (dmem_req_valid)
			busy <= 1'b1;
		else if (dmem_rsp_valid)
			busy <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (done && is_load)
			load_val <= dmem_rsp.rdata;
	end

endmodule

/* src/rv_regfile.sv */
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module rv_regfile (
	input  logic        clock,
	input  logic        rst_n,
	input  logic [3:0]  raddr1,
	input  logic [3:0]  raddr2,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2,
	input  logic        we,
	input  logic [3:0]  waddr,
	input  logic [31:0] wdata
);
	logic [31:0] regs [`RV_REG_COUNT];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `RV_REG_COUNT; i++)
				regs[i] <= '0;
		end else if (we && waddr != 4'd0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 == 4'd0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == 4'd0) ? '0 : regs[raddr2];

endmodule
